/* common/rf_ctl_pkg.sv */
`default_nettype none

package rf_ctl_pkg;

	// Field ADC sample straight from the converter
	typedef logic signed [15:0] adc_t;

	// Interleaved I/Q word
	// Feedback input, feedback output and drive all use it
	typedef logic signed [17:0] iq_t;

	// LO cosine or sine
	typedef logic signed [17:0] lo_t;

	// One DAC sample
	typedef logic signed [15:0] dac_t;

	// DDS phase step and accumulator
	typedef logic [31:0] phase_t;

	// Proportional gain, 8 fraction bits
	typedef logic signed [15:0] gain_t;

	// Fraction bits of gain_t
	localparam int gain_frac_bits = 8;

	// Index width of the LO table, 32 entries
	localparam int lo_tab_bits = 5;

	// Feedback core waits for the first sync
	// so the I/Q slot alignment is known before it drives
	typedef enum logic {
		fdbk_idle,
		fdbk_run
	} fdbk_state_e;

endpackage

`default_nettype wire

/* rtl/rf_timing.sv */
`default_nettype none

module rf_timing #(
	parameter int cic_period = 33
) (
	input wire clk,
	input wire ctlr_ph_reset,
	input wire qsync_rx,
	input wire [1:0] use_fiber_iq,
	input wire [7:0] wave_samp_per,
	output logic iq,
	output logic sync,
	output logic sample_tick,
	output logic wave_strobe
);

	localparam int cic_w = $clog2(cic_period);

	logic [2:0] state;
	logic state_reset;
	logic [2:0] sync_state;
	logic [cic_w-1:0] cic_state;
	logic [7:0] wave_cnt;

	// Fiber link resyncs the divider
	assign state_reset = qsync_rx & use_fiber_iq[0];
	// Swapping slots flips handedness of the I/Q frame
	assign sync_state = use_fiber_iq[1] ? 3'd1 : 3'd2;

	// I/Q divider and feedback sync
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			state <= '0;
			sync <= 1'b0;
		end else begin
			if (state_reset)
				state <= sync_state;
			else
				state <= state + 3'd1;
			// One cycle after state 6
			sync <= (state == 3'd6);
		end
	end

	// Even states are I, odd are Q
	assign iq = state[0];

	// Sample tick divider and waveform decimation
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			cic_state <= '0;
			sample_tick <= 1'b0;
			wave_cnt <= '0;
		end else begin
			if (cic_state == cic_w'(cic_period - 1))
				cic_state <= '0;
			else
				cic_state <= cic_state + 1'b1;
			sample_tick <= (cic_state == '0);
			// Counter starts empty and loads on the first tick
			if (sample_tick) begin
				if (wave_cnt <= 8'd1)
					wave_cnt <= wave_samp_per;
				else
					wave_cnt <= wave_cnt - 8'd1;
			end
		end
	end

	// Only the tick where the count reads 1 feeds capture
	assign wave_strobe = sample_tick & (wave_cnt == 8'd1);

endmodule

`default_nettype wire

/* rtl/lo_dds.sv */
`default_nettype none

module lo_dds #(
	parameter int lo_amp = 74694
) (
	input wire clk,
	input wire ctlr_ph_reset,
	input wire rf_ctl_pkg::phase_t phase_step,
	input wire [11:0] modulo,
	output rf_ctl_pkg::lo_t cos_lo,
	output rf_ctl_pkg::lo_t sin_lo
);

	localparam int tab_len = 1 << rf_ctl_pkg::lo_tab_bits;

	// Quarter wave of cosine in Q16 with steps of 2*pi/32
	function automatic int quarter_q16(input int k);
		case (k)
			0: return 65536;
			1: return 64277;
			2: return 60547;
			3: return 54491;
			4: return 46341;
			5: return 36410;
			6: return 25080;
			7: return 12785;
			default: return 0;
		endcase
	endfunction

	// Full wave from the quarter by symmetry
	function automatic int cos_q16(input int k);
		int m;
		m = k % 32;
		if (m <= 8)
			return quarter_q16(m);
		else if (m <= 16)
			return -quarter_q16(16 - m);
		else if (m <= 24)
			return -quarter_q16(m - 16);
		else
			return quarter_q16(32 - m);
	endfunction

	// Scale by lo_amp with rounding
	function automatic rf_ctl_pkg::lo_t lo_entry(input int k);
		longint prod;
		prod = longint'(lo_amp) * longint'(cos_q16(k));
		return rf_ctl_pkg::lo_t'((prod + 64'sd32768) >>> 16);
	endfunction

	rf_ctl_pkg::lo_t cos_tab [tab_len];
	rf_ctl_pkg::lo_t sin_tab [tab_len];
	rf_ctl_pkg::phase_t acc;
	logic [12:0] res_sum;
	logic [12:0] res_lim;
	logic carry;
	logic [rf_ctl_pkg::lo_tab_bits-1:0] idx;

	// Constant tables where sine is cosine a quarter turn back
	for (genvar k = 0; k < tab_len; k++) begin : g_tab
		assign cos_tab[k] = lo_entry(k);
		assign sin_tab[k] = lo_entry(k + 24);
	end

	// Fine residue wraps at modulo
	// Zero modulo means plain 12-bit wrap
	assign res_sum = {1'b0, acc[11:0]} + {1'b0, phase_step[11:0]};
	assign res_lim = (modulo == 12'd0) ? 13'h1000 : {1'b0, modulo};
	assign carry = (res_sum >= res_lim);

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			acc <= '0;
		end else begin
			// Extra count on residue overflow keeps IF ratio exact
			acc[31:12] <= acc[31:12] + phase_step[31:12] + {19'd0, carry};
			acc[11:0] <= carry ? 12'(res_sum - res_lim) : res_sum[11:0];
		end
	end

	assign idx = acc[31:32-rf_ctl_pkg::lo_tab_bits];

	// Table lookup takes one cycle
	always_ff @(posedge clk) begin
		cos_lo <= cos_tab[idx];
		sin_lo <= sin_tab[idx];
	end

endmodule

`default_nettype wire

/* rtl/field_downconvert.sv */
`default_nettype none

module field_downconvert (
	input wire clk,
	input wire ctlr_ph_reset,
	input wire rf_ctl_pkg::adc_t a_field,
	input wire iq,
	input wire rf_ctl_pkg::lo_t cos_lo,
	input wire rf_ctl_pkg::lo_t sin_lo,
	output rf_ctl_pkg::iq_t field_xy
);

	// DC tracker holds its estimate in the upper half
	logic signed [31:0] dc_acc;
	logic signed [16:0] washed;
	logic signed [16:0] washed_r;
	rf_ctl_pkg::lo_t lo_r;
	logic signed [34:0] mix;

	// One extra bit so the subtraction cannot wrap
	assign washed = {a_field[15], a_field} - {dc_acc[31], dc_acc[31:16]};

	// Time constant about 2^16 clocks
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset)
			dc_acc <= '0;
		else
			dc_acc <= dc_acc + {{15{washed[16]}}, washed};
	end

	// Stage 1
	// Hold washed sample and pick the LO channel for this slot
	always_ff @(posedge clk) begin
		washed_r <= washed;
		lo_r <= iq ? sin_lo : cos_lo;
	end

	// Full precision product
	assign mix = washed_r * lo_r;

	// Stage 2
	// LO peak is below 2^17, so bits above 33 carry only sign
	always_ff @(posedge clk) begin
		field_xy <= mix[33:16];
	end

endmodule

`default_nettype wire

/* fdbk/fdbk_core.sv */
`default_nettype none

module fdbk_core (
	input wire clk,
	input wire ctlr_ph_reset,
	input wire iq,
	input wire sync,
	input wire use_fiber,
	input wire rf_ctl_pkg::iq_t field_xy,
	input wire [16:0] iq_recv,
	input wire rf_ctl_pkg::iq_t set_x,
	input wire rf_ctl_pkg::iq_t set_y,
	input wire rf_ctl_pkg::gain_t gain,
	input wire [16:0] drive_limit,
	output rf_ctl_pkg::iq_t out_xy,
	output logic sat
);

	localparam int fb = rf_ctl_pkg::gain_frac_bits;

	rf_ctl_pkg::fdbk_state_e state;
	rf_ctl_pkg::iq_t in_xy;
	rf_ctl_pkg::iq_t set_sel;
	rf_ctl_pkg::iq_t set_r;
	logic signed [18:0] err;
	logic signed [18:0] err_r;
	logic signed [34:0] prod;
	logic signed [34-fb:0] corr;
	logic signed [27:0] sum;
	logic signed [27:0] lim_hi;
	logic signed [27:0] lim_lo;
	logic over;
	logic under;

	// Wait for first sync after reset
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset)
			state <= rf_ctl_pkg::fdbk_idle;
		else if (sync)
			state <= rf_ctl_pkg::fdbk_run;
	end

	// Fiber word is 17 bits and left aligned
	assign in_xy = use_fiber ? {iq_recv, 1'b0} : field_xy;
	// Setpoint of the current slot
	assign set_sel = iq ? set_y : set_x;
	// Error with a guard bit
	assign err = {set_sel[17], set_sel} - {in_xy[17], in_xy};

	// Stage 1
	always_ff @(posedge clk) begin
		set_r <= set_sel;
		err_r <= err;
	end

	// Proportional term without the gain fraction
	assign prod = err_r * gain;
	assign corr = prod[34:fb];
	assign sum = {{10{set_r[17]}}, set_r} + {{(fb-7){corr[34-fb]}}, corr};

	// Symmetric clip window
	assign lim_hi = {11'd0, drive_limit};
	assign lim_lo = -lim_hi;
	assign over = (sum > lim_hi);
	assign under = (sum < lim_lo);

	// Stage 2
	// Zero out until the slots are known
	always_ff @(posedge clk) begin
		if (state == rf_ctl_pkg::fdbk_run) begin
			if (over)
				out_xy <= lim_hi[17:0];
			else if (under)
				out_xy <= lim_lo[17:0];
			else
				out_xy <= sum[17:0];
			sat <= over | under;
		end else begin
			out_xy <= '0;
			sat <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/drive_filter.sv */
`default_nettype none

module drive_filter #(
	parameter int lp_shift = 3
) (
	input wire clk,
	input wire ctlr_ph_reset,
	input wire iq,
	input wire rf_ctl_pkg::iq_t x,
	output rf_ctl_pkg::iq_t y
);

	// Extra fraction bits so the loop settles on x
	localparam int aw = 18 + lp_shift;

	logic signed [aw-1:0] acc [2];
	logic signed [aw-1:0] x_w;
	logic signed [aw:0] diff;
	logic signed [aw:0] diff_r;
	logic signed [aw:0] step;
	logic signed [aw-1:0] sum;
	logic iq_r;

	// Input aligned to accumulator scale
	assign x_w = x <<< lp_shift;

	// Stage 1
	// Error against this slot's accumulator
	assign diff = x_w - acc[iq];

	always_ff @(posedge clk) begin
		diff_r <= diff;
		iq_r <= iq;
	end

	// Stage 2
	// Same slot comes back after two clocks, update is in place by then
	assign step = diff_r >>> lp_shift;
	assign sum = acc[iq_r] + step[aw-1:0];

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			acc[0] <= '0;
			acc[1] <= '0;
		end else begin
			acc[iq_r] <= sum;
		end
	end

	// Output drops the fraction bits
	always_ff @(posedge clk) begin
		y <= sum[aw-1:lp_shift];
	end

endmodule

`default_nettype wire

/* rtl/if_upconvert.sv */
`default_nettype none

module if_upconvert (
	input wire clk,
	input wire ctlr_ph_reset,
	input wire iq,
	input wire rf_ctl_pkg::iq_t drive,
	input wire rf_ctl_pkg::lo_t cos_lo,
	input wire rf_ctl_pkg::lo_t sin_lo,
	output rf_ctl_pkg::dac_t dac1_out0,
	output rf_ctl_pkg::dac_t dac1_out1,
	output rf_ctl_pkg::dac_t dac2_out0,
	output rf_ctl_pkg::dac_t dac2_out1
);

	// Shift down by 17 and clip to DAC range
	function automatic rf_ctl_pkg::dac_t dac_clip(input logic signed [36:0] v);
		logic signed [19:0] s;
		s = v[36:17];
		if (s > 20'sd32767)
			return 16'sh7fff;
		else if (s < -20'sd32768)
			return 16'sh8000;
		else
			return s[15:0];
	endfunction

	rf_ctl_pkg::lo_t cos_b;
	rf_ctl_pkg::lo_t sin_b;
	rf_ctl_pkg::iq_t i_r;
	rf_ctl_pkg::iq_t q_r;
	logic pair_rdy;
	logic signed [36:0] mix1;
	logic signed [36:0] mix2;
	rf_ctl_pkg::dac_t dac1_r;
	rf_ctl_pkg::dac_t dac2_r;

	// Flags the cycle after Q was taken
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset)
			pair_rdy <= 1'b0;
		else
			pair_rdy <= iq;
	end

	always_ff @(posedge clk) begin
		// LO up by 1/16 to restore full scale
		cos_b <= cos_lo + (cos_lo >>> 4);
		sin_b <= sin_lo + (sin_lo >>> 4);
		// Pair capture
		if (iq)
			q_r <= drive;
		else
			i_r <= drive;
		if (pair_rdy) begin
			dac1_r <= dac_clip(mix1);
			dac2_r <= dac_clip(mix2);
		end
	end

	// Single sideband rotation
	assign mix1 = i_r * cos_b - q_r * sin_b;
	assign mix2 = i_r * sin_b + q_r * cos_b;

	// Both DAC phases carry the same sample
	assign dac1_out0 = dac1_r;
	assign dac1_out1 = dac1_r;
	assign dac2_out0 = dac2_r;
	assign dac2_out1 = dac2_r;

endmodule

`default_nettype wire

/* rtl/rf_controller.sv */
`default_nettype none

module rf_controller #(
	parameter int cic_period = 33,
	parameter int lo_amp = 74694,
	parameter int lp_shift = 3
) (
	input wire clk,
	input wire ctlr_ph_reset,
	// Field ADC at IF
	input wire rf_ctl_pkg::adc_t a_field,
	// Fiber link I/Q and its slot sync
	input wire [16:0] iq_recv,
	input wire qsync_rx,
	// Host registers
	input wire [1:0] use_fiber_iq,
	input wire rf_ctl_pkg::phase_t phase_step,
	input wire [11:0] modulo,
	input wire [7:0] wave_samp_per,
	input wire rf_ctl_pkg::iq_t set_x,
	input wire rf_ctl_pkg::iq_t set_y,
	input wire rf_ctl_pkg::gain_t gain,
	input wire [16:0] drive_limit,
	// Baseband drive with its slot named by iq
	output wire iq,
	output wire rf_ctl_pkg::iq_t drive,
	output wire sat,
	// Strobes
	output wire sample_tick,
	output wire wave_strobe,
	// SSB DAC streams
	output wire rf_ctl_pkg::dac_t dac1_out0,
	output wire rf_ctl_pkg::dac_t dac1_out1,
	output wire rf_ctl_pkg::dac_t dac2_out0,
	output wire rf_ctl_pkg::dac_t dac2_out1
);

	wire sync;
	wire rf_ctl_pkg::lo_t cos_lo;
	wire rf_ctl_pkg::lo_t sin_lo;
	wire rf_ctl_pkg::iq_t field_xy;
	wire rf_ctl_pkg::iq_t fdbk_out_xy;

	// Slot phase and strobes
	rf_timing #(.cic_period(cic_period)) i_rf_timing (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.qsync_rx(qsync_rx), .use_fiber_iq(use_fiber_iq),
		.wave_samp_per(wave_samp_per),
		.iq(iq), .sync(sync),
		.sample_tick(sample_tick), .wave_strobe(wave_strobe)
	);

	// LO
	lo_dds #(.lo_amp(lo_amp)) i_lo_dds (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.phase_step(phase_step), .modulo(modulo),
		.cos_lo(cos_lo), .sin_lo(sin_lo)
	);

	// Local field to I/Q
	field_downconvert i_field_downconvert (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.a_field(a_field), .iq(iq),
		.cos_lo(cos_lo), .sin_lo(sin_lo),
		.field_xy(field_xy)
	);

	// Loop core with two cycles of latency
	fdbk_core i_fdbk_core (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.iq(iq), .sync(sync), .use_fiber(use_fiber_iq[0]),
		.field_xy(field_xy), .iq_recv(iq_recv),
		.set_x(set_x), .set_y(set_y), .gain(gain),
		.drive_limit(drive_limit),
		.out_xy(fdbk_out_xy), .sat(sat)
	);

	// Drive smoothing takes two more cycles and keeps the slots lined up
	drive_filter #(.lp_shift(lp_shift)) i_drive_filter (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.iq(iq), .x(fdbk_out_xy), .y(drive)
	);

	// Back to IF for the DACs
	if_upconvert i_if_upconvert (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.iq(iq), .drive(drive),
		.cos_lo(cos_lo), .sin_lo(sin_lo),
		.dac1_out0(dac1_out0), .dac1_out1(dac1_out1),
		.dac2_out0(dac2_out0), .dac2_out1(dac2_out1)
	);

endmodule

`default_nettype wire

/* tb/tb_rf_controller.sv */
`default_nettype none

module tb_rf_controller;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int cic_period = 33;
	localparam int lo_amp = 74694;
	localparam int lp_shift = 3;

	// Run length budget in clocks
	localparam int reset_cycles = 16;
	localparam int iq_test_cycles = 64;
	localparam int max_wave_per = 5;
	localparam int wave_test_cycles = 5 * max_wave_per * cic_period;
	localparam int settle_cycles = 300;
	localparam int window_cycles = 40;
	localparam int margin_cycles = 250;
	localparam int max_cycles = reset_cycles + iq_test_cycles + 2 * wave_test_cycles
		+ 3 * (settle_cycles + window_cycles) + margin_cycles;

	logic clk;
	logic ctlr_ph_reset;
	rf_ctl_pkg::adc_t a_field;
	logic [16:0] iq_recv;
	logic qsync_rx;
	logic [1:0] use_fiber_iq;
	rf_ctl_pkg::phase_t phase_step;
	logic [11:0] modulo;
	logic [7:0] wave_samp_per;
	rf_ctl_pkg::iq_t set_x;
	rf_ctl_pkg::iq_t set_y;
	rf_ctl_pkg::gain_t gain;
	logic [16:0] drive_limit;
	wire iq;
	wire rf_ctl_pkg::iq_t drive;
	wire sat;
	wire sample_tick;
	wire wave_strobe;
	wire rf_ctl_pkg::dac_t dac1_out0;
	wire rf_ctl_pkg::dac_t dac1_out1;
	wire rf_ctl_pkg::dac_t dac2_out0;
	wire rf_ctl_pkg::dac_t dac2_out1;

	logic [31:0] lfsr;
	int errors;
	int checks;
	int cycles;

	// Checker state
	// Reference I/Q state divider
	logic [2:0] model_state;
	logic tick_seen;
	int tick_gap;
	int strobes_since_per;
	int ticks_since_strobe;
	logic [7:0] last_per;

	// Expected settled values and check enables
	logic chk_set;
	logic chk_lim;
	logic chk_dac;
	longint exp_x;
	longint exp_y;

	rf_controller #(
		.cic_period(cic_period),
		.lo_amp(lo_amp),
		.lp_shift(lp_shift)
	) i_rf_controller (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.a_field(a_field), .iq_recv(iq_recv), .qsync_rx(qsync_rx),
		.use_fiber_iq(use_fiber_iq), .phase_step(phase_step), .modulo(modulo),
		.wave_samp_per(wave_samp_per), .set_x(set_x), .set_y(set_y),
		.gain(gain), .drive_limit(drive_limit),
		.iq(iq), .drive(drive), .sat(sat),
		.sample_tick(sample_tick), .wave_strobe(wave_strobe),
		.dac1_out0(dac1_out0), .dac1_out1(dac1_out1),
		.dac2_out0(dac2_out0), .dac2_out1(dac2_out1)
	);

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic longint abs_diff(input longint a, input longint b);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	task automatic flag_mismatch(input string msg);
		errors++;
		$display("ERROR at %0d ns: %s", $time, msg);
	endtask

	task automatic count_strobes(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (wave_strobe)
				seen++;
		end
	endtask

	task automatic random_setpoints();
		logic [15:0] rx;
		logic [15:0] ry;
		rx = 16'(lfsr_bits(16));
		ry = 16'(lfsr_bits(16));
		set_x = {{2{rx[15]}}, rx};
		set_y = {{2{ry[15]}}, ry};
		exp_x = longint'($signed(set_x));
		exp_y = longint'($signed(set_y));
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Timeout guard
	initial cycles = 0;
	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout, run did not finish within %0d cycles", max_cycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Verification failed");
			$finish;
		end
	end

	// Checkers on the rising edge see the values of the cycle just ended
	always @(posedge clk) begin
		longint cb;
		longint e1;
		longint e2;
		if (ctlr_ph_reset) begin
			model_state = 3'd0;
			tick_seen = 1'b0;
			tick_gap = 0;
			strobes_since_per = 0;
			ticks_since_strobe = 0;
			last_per = wave_samp_per;
		end else begin
			// I/Q slot against the reference divider
			checks++;
			assert (iq == model_state[0]) else flag_mismatch(
				$sformatf("iq is %0d, expected %0d", iq, model_state[0]));
			// Fiber sync loads 1 or 2 and the divider counts up otherwise
			if (qsync_rx && use_fiber_iq[0])
				model_state = use_fiber_iq[1] ? 3'd1 : 3'd2;
			else
				model_state = model_state + 3'd1;

			// Sample tick spacing
			tick_gap++;
			if (sample_tick) begin
				if (tick_seen) begin
					checks++;
					assert (tick_gap == cic_period) else flag_mismatch(
						$sformatf("sample_tick gap %0d, expected %0d", tick_gap, cic_period));
				end
				tick_seen = 1'b1;
				tick_gap = 0;
			end

			// First waveform strobe after a period change only restarts the count
			if (wave_samp_per != last_per) begin
				strobes_since_per = 0;
				last_per = wave_samp_per;
			end
			checks++;
			assert (!wave_strobe || sample_tick) else flag_mismatch(
				"wave_strobe high without sample_tick");
			if (sample_tick)
				ticks_since_strobe++;
			if (wave_strobe) begin
				if (strobes_since_per > 0) begin
					checks++;
					assert (ticks_since_strobe == int'(wave_samp_per)) else flag_mismatch(
						$sformatf("wave_strobe every %0d ticks, expected %0d",
							ticks_since_strobe, wave_samp_per));
				end
				strobes_since_per++;
				ticks_since_strobe = 0;
			end

			// Settled drive against the setpoint of its slot
			if (chk_set) begin
				checks++;
				assert (abs_diff(longint'(drive), iq ? exp_y : exp_x) <= 2) else
					flag_mismatch($sformatf("drive %0d in slot %0d, expected %0d",
						drive, iq, iq ? exp_y : exp_x));
			end

			// Clipped drive and saturation flag
			if (chk_lim) begin
				checks += 2;
				assert (abs_diff(abs_diff(longint'(drive), 0), longint'(drive_limit)) <= 2)
				else flag_mismatch($sformatf("drive %0d, expected magnitude %0d",
					drive, drive_limit));
				assert (sat) else flag_mismatch("sat low while drive is clipped");
			end

			// LO at phase zero gives the boosted amplitude on cos and zero on sin
			if (chk_dac) begin
				cb = longint'(lo_amp) + (longint'(lo_amp) >>> 4);
				e1 = (exp_x * cb - exp_y * 0) >>> 17;
				e2 = (exp_x * 0 + exp_y * cb) >>> 17;
				checks += 4;
				assert (abs_diff(longint'(dac1_out0), e1) <= 2) else
					flag_mismatch($sformatf("dac1_out0 %0d, expected %0d", dac1_out0, e1));
				assert (abs_diff(longint'(dac2_out0), e2) <= 2) else
					flag_mismatch($sformatf("dac2_out0 %0d, expected %0d", dac2_out0, e2));
				assert (abs_diff(longint'(dac1_out1), e1) <= 2) else
					flag_mismatch($sformatf("dac1_out1 %0d, expected %0d", dac1_out1, e1));
				assert (abs_diff(longint'(dac2_out1), e2) <= 2) else
					flag_mismatch($sformatf("dac2_out1 %0d, expected %0d", dac2_out1, e2));
			end
		end
	end

	// Stimulus driven on the falling edge
	initial begin
		logic [7:0] per;
		lfsr = 32'h24da;
		errors = 0;
		checks = 0;
		chk_set = 1'b0;
		chk_lim = 1'b0;
		chk_dac = 1'b0;
		exp_x = 0;
		exp_y = 0;
		ctlr_ph_reset = 1'b1;
		a_field = 16'sd1200;
		iq_recv = '0;
		qsync_rx = 1'b0;
		use_fiber_iq = 2'b01;
		phase_step = '0;
		modulo = '0;
		wave_samp_per = 8'd3;
		set_x = '0;
		set_y = '0;
		gain = '0;
		drive_limit = 17'd100000;
		repeat (reset_cycles) @(negedge clk);
		ctlr_ph_reset = 1'b0;

		// Resync with both slot orders
		for (int k = 0; k < 4; k++) begin
			use_fiber_iq = {k[0], 1'b1};
			repeat (5 + k) @(negedge clk);
			qsync_rx = 1'b1;
			@(negedge clk);
			qsync_rx = 1'b0;
		end
		repeat (8) @(negedge clk);

		// Two random decimation periods
		per = 8'd2 + 8'(lfsr_bits(2));
		wave_samp_per = per;
		count_strobes(4);
		per = (per == 8'd5) ? 8'd2 : per + 8'd1;
		wave_samp_per = per;
		count_strobes(4);

		// Fiber input with zero gain
		iq_recv = 17'(lfsr_bits(17));
		random_setpoints();
		repeat (settle_cycles) @(negedge clk);
		chk_set = 1'b1;
		repeat (window_cycles) @(negedge clk);
		chk_set = 1'b0;

		// Large gain with the input far above the setpoint
		drive_limit = 17'd50000;
		gain = 16'sh4000;
		iq_recv = 17'h0f000;
		set_x = 18'sd1000;
		set_y = -18'sd1000;
		repeat (settle_cycles) @(negedge clk);
		chk_lim = 1'b1;
		repeat (window_cycles) @(negedge clk);
		chk_lim = 1'b0;

		// DAC mixing with the LO held at phase zero
		drive_limit = 17'd100000;
		gain = '0;
		random_setpoints();
		repeat (settle_cycles) @(negedge clk);
		chk_set = 1'b1;
		chk_dac = 1'b1;
		repeat (window_cycles) @(negedge clk);
		chk_set = 1'b0;
		chk_dac = 1'b0;

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
common/rf_ctl_pkg.sv
rtl/rf_timing.sv
rtl/lo_dds.sv
rtl/field_downconvert.sv
fdbk/fdbk_core.sv
rtl/drive_filter.sv
rtl/if_upconvert.sv
rtl/rf_controller.sv
tb/tb_rf_controller.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RF controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rf_controller \
	-f tb.f \
	-o tb_rf_controller_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_rf_controller_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" sim.log; then
	exit 0
fi
exit 1
